/* dv/tb_viterbi_decoder.sv */
`timescale 1ns/1ps

module tb_viterbi_decoder;

   localparam int CLK_PERIOD = 20;
   localparam int BLOCK_LEN  = viterbi_pkg::BLOCK_LEN_DEFAULT;
   localparam int SEED       = 69;
   localparam int IDLE_START = 10;
   localparam int IDLE_GAP   = 5;
   localparam int LEN_CLEAN  = 200;
   localparam int LEN_NOISY  = 400;
   localparam int LEN_LONG   = 4000;
   localparam int LEN_FRESH  = 300;
   // At most one flipped symbol bit per window
   localparam int ERR_WINDOW = 24;

   localparam int TOTAL_SYMBOLS   = LEN_CLEAN + LEN_NOISY + LEN_LONG + LEN_FRESH;
   localparam int WATCHDOG_CYCLES = 40 * TOTAL_SYMBOLS + 8 * BLOCK_LEN;

   // Encoder taps over {state, new bit}
   localparam logic [3:0] TAPS_0 = 4'b1101;
   localparam logic [3:0] TAPS_1 = 4'b1111;

   logic                 clk;
   logic                 rst;
   logic                 enable;
   viterbi_pkg::symbol_t symbol;
   logic                 dec_bit;
   logic                 dec_valid;

   logic expected_q [$];
   logic exp_bit;
   int   decoded_cnt;
   int   norm_count;

   viterbi_decoder dut0
   (
      .clk         (clk),
      .rst         (rst),
      .enable_i    (enable),
      .symbol_i    (symbol),
      .bit_o       (dec_bit),
      .bit_valid_o (dec_valid)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Reference encoder, state holds the last 3 bits with the newest in bit 0
   function automatic viterbi_pkg::symbol_t conv_encode(input logic in_bit,
                                                        input logic [2:0] state);
      logic [3:0]           shift_reg;
      viterbi_pkg::symbol_t sym;
      shift_reg = {state, in_bit};
      sym[0]    = ^(shift_reg & TAPS_0);
      sym[1]    = ^(shift_reg & TAPS_1);
      return sym;
   endfunction

   task automatic idle_cycles(input int n);
      enable = 1'b0;
      symbol = '0;
      repeat (n)
      begin
         @(negedge clk);
         assert (dec_valid === 1'b0)
         else
         begin
            $display("error bit_valid_o expected 0x0 actual 0x%h", dec_valid);
            $display("Simulation FAILED");
            $fatal(1, "output valid while the decoder is idle");
         end
      end
   endtask

   // Sends random bits until n_bits have come back decoded
   task automatic run_stream(input int n_bits, input logic with_errors);
      logic [2:0]           enc_state;
      logic                 src;
      int                   idx;
      int                   err_pos;
      int                   flip_bit;
      viterbi_pkg::symbol_t sym;
      expected_q.delete();
      decoded_cnt = 0;
      enc_state   = '0;
      idx         = 0;
      err_pos     = -1;
      while (decoded_cnt < n_bits)
      begin
         // Flip position kept away from the window edges
         if (with_errors && (idx % ERR_WINDOW == 0))
            err_pos = idx + $urandom_range(4, 19);
         src       = 1'($urandom_range(0, 1));
         sym       = conv_encode(src, enc_state);
         enc_state = {enc_state[1:0], src};
         if (idx == err_pos)
         begin
            flip_bit      = $urandom_range(0, 1);
            sym[flip_bit] = ~sym[flip_bit];
         end
         expected_q.push_back(src);
         enable = 1'b1;
         symbol = sym;
         idx++;
         @(negedge clk);
      end
   endtask

   always @(posedge clk)
   begin
      if (dec_valid === 1'b1)
      begin
         assert (expected_q.size() > 0)
         else
         begin
            $display("Decoder produced an output bit while no source bit was pending");
            $display("Simulation FAILED");
            $fatal(1, "unexpected output bit");
         end
         exp_bit = expected_q.pop_front();
         decoded_cnt++;
         assert (dec_bit === exp_bit)
         else
         begin
            $display("error bit_o expected 0x%h actual 0x%h at bit %0d",
                     exp_bit, dec_bit, decoded_cnt - 1);
            $display("Simulation FAILED");
            $fatal(1, "decoded bit mismatch");
         end
      end
   end

   // Counts cycles where the path metrics get renormalized
   always @(posedge clk)
   begin
      if (enable === 1'b1 && dut0.u_acs.norm === 1'b1)
         norm_count++;
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Decoding stalled, no result after %0d cycles", WATCHDOG_CYCLES);
      $display("Simulation FAILED");
      $fatal(1, "watchdog timeout");
   end

   initial
   begin
      void'($urandom(SEED));
      rst         = 1'b0;
      enable      = 1'b0;
      symbol      = '0;
      decoded_cnt = 0;
      norm_count  = 0;
      repeat (3) @(negedge clk);
      rst = 1'b1;

      idle_cycles(IDLE_START);
      run_stream(LEN_CLEAN, 1'b0);

      idle_cycles(IDLE_GAP);
      run_stream(LEN_NOISY, 1'b1);

      idle_cycles(IDLE_GAP);
      norm_count = 0;
      run_stream(LEN_LONG, 1'b1);
      assert (norm_count > 0)
      else
      begin
         $display("Path metrics were never normalized during the long run");
         $display("Simulation FAILED");
         $fatal(1, "no normalization seen");
      end

      // Stream is cut off mid-flight, the output must restart cleanly
      idle_cycles(IDLE_GAP);
      run_stream(LEN_FRESH, 1'b1);

      $display("Simulation PASSED");
      $finish;
   end

endmodule

/* src/acs_array.sv */
`timescale 1ns/1ps

module acs_array
#(
   parameter int PM_W = viterbi_pkg::PM_W_DEFAULT
)
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  enable_i,
   input  logic [2*viterbi_pkg::NUM_STATES-1:0][viterbi_pkg::BM_W-1:0] bm_i,
   output viterbi_pkg::decision_t decision_o
);

   localparam int NS = viterbi_pkg::NUM_STATES;
   localparam int SW = viterbi_pkg::STATE_W;

   logic [NS-1:0][PM_W-1:0]  pm_q;
   logic [NS-1:0][PM_W-1:0]  pm_d;
   logic [NS-1:0]            valid_q;
   logic [NS-1:0]            valid_d;
   logic [NS-1:0]            msb;
   viterbi_pkg::decision_t   sel_d;
   logic                     norm;

   // One add-compare-select per next state
   always_comb
   begin
      logic [SW-1:0]   st;
      logic [SW-1:0]   p0;
      logic [SW-1:0]   p1;
      logic [PM_W-1:0] sum0;
      logic [PM_W-1:0] sum1;

      for (int n = 0; n < NS; n++)
      begin
         st   = SW'(n);
         p0   = {1'b0, st[SW-1:1]};
         p1   = {1'b1, st[SW-1:1]};
         sum0 = pm_q[p0] + PM_W'(bm_i[{p0, st[0]}]);
         sum1 = pm_q[p1] + PM_W'(bm_i[{p1, st[0]}]);

         // Tie keeps the predecessor with the high bit clear
         sel_d[n]   = valid_q[p1] && (!valid_q[p0] || (sum1 < sum0));
         valid_d[n] = valid_q[p0] | valid_q[p1];
         if (!valid_d[n])
            pm_d[n] = '0;
         else
            pm_d[n] = sel_d[n] ? sum1 : sum0;
         msb[n] = pm_q[n][PM_W-1];
      end
      norm = &msb;
   end

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         pm_q       <= '0;
         valid_q    <= NS'(1);
         decision_o <= '0;
      end
      else if (!enable_i)
      begin
         pm_q       <= '0;
         valid_q    <= NS'(1);
         decision_o <= '0;
      end
      else
      begin
         valid_q    <= valid_d;
         decision_o <= sel_d;
         for (int n = 0; n < NS; n++)
         begin
            // Drop the MSB once every metric carries it
            if (norm)
               pm_q[n] <= {1'b0, pm_d[n][PM_W-2:0]};
            else
               pm_q[n] <= pm_d[n];
         end
      end
   end

endmodule

/* src/bit_reorder.sv */
`timescale 1ns/1ps

module bit_reorder
#(
   parameter int BLOCK_LEN = viterbi_pkg::BLOCK_LEN_DEFAULT
)
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 enable_i,
   input  viterbi_pkg::tb_bit_t bit_0_i,
   input  viterbi_pkg::tb_bit_t bit_1_i,
   output logic                 bit_o,
   output logic                 bit_valid_o
);

   localparam int ADDR_W = (BLOCK_LEN > 1) ? $clog2(BLOCK_LEN) : 1;
   localparam logic [ADDR_W-1:0] LAST = ADDR_W'(BLOCK_LEN - 1);

   logic              bank_mem [2][BLOCK_LEN];
   logic [ADDR_W-1:0] wr_ptr;
   logic [ADDR_W-1:0] rd_ptr;
   logic              rd_bank;
   logic              filled;
   logic              rd_vld_q;
   logic              rd_bit_q;
   logic              in_vld;

   assign in_vld = bit_0_i.valid | bit_1_i.valid;

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         wr_ptr      <= LAST;
         rd_ptr      <= '0;
         rd_bank     <= 1'b0;
         filled      <= 1'b0;
         rd_vld_q    <= 1'b0;
         bit_valid_o <= 1'b0;
      end
      else if (!enable_i)
      begin
         wr_ptr      <= LAST;
         rd_ptr      <= '0;
         rd_bank     <= 1'b0;
         filled      <= 1'b0;
         rd_vld_q    <= 1'b0;
         bit_valid_o <= 1'b0;
      end
      else
      begin
         if (in_vld)
         begin
            wr_ptr <= (wr_ptr == '0) ? LAST : wr_ptr - 1'b1;
            rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            // Block done, read it back during the next one
            if (wr_ptr == '0)
            begin
               rd_bank <= bit_1_i.valid;
               filled  <= 1'b1;
            end
         end
         rd_vld_q    <= in_vld & filled;
         bit_valid_o <= rd_vld_q;
      end
   end

   always_ff @(posedge clk)
   begin
      if (bit_0_i.valid)
         bank_mem[0][wr_ptr] <= bit_0_i.data;
      if (bit_1_i.valid)
         bank_mem[1][wr_ptr] <= bit_1_i.data;
      rd_bit_q <= bank_mem[rd_bank][rd_ptr];
      bit_o    <= rd_bit_q;
   end

endmodule

/* src/branch_metric.sv */
`timescale 1ns/1ps

module branch_metric
(
   input  viterbi_pkg::symbol_t symbol_i,
   output logic [2*viterbi_pkg::NUM_STATES-1:0][viterbi_pkg::BM_W-1:0] bm_o
);

   localparam int NUM_BRANCH = 2 * viterbi_pkg::NUM_STATES;
   localparam int BRANCH_W   = viterbi_pkg::STATE_W + 1;
   localparam int BM_W       = viterbi_pkg::BM_W;

   // Branch index is {source state, new bit}
   always_comb
   begin
      logic [BRANCH_W-1:0]  branch;
      viterbi_pkg::symbol_t expected;
      viterbi_pkg::symbol_t diff;

      for (int r = 0; r < NUM_BRANCH; r++)
      begin
         branch      = BRANCH_W'(r);
         expected[0] = ^(branch & viterbi_pkg::GEN_0);
         expected[1] = ^(branch & viterbi_pkg::GEN_1);
         diff        = symbol_i ^ expected;
         bm_o[r]     = BM_W'(diff[0]) + BM_W'(diff[1]);
      end
   end

endmodule

/* src/survivor_memory.sv */
`timescale 1ns/1ps

module survivor_memory
#(
   parameter int BLOCK_LEN = viterbi_pkg::BLOCK_LEN_DEFAULT
)
(
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   enable_i,
   input  viterbi_pkg::decision_t decision_i,
   output viterbi_pkg::tb_feed_t  feed_0_o,
   output viterbi_pkg::tb_feed_t  feed_1_o
);

   localparam int ADDR_W = (BLOCK_LEN > 1) ? $clog2(BLOCK_LEN) : 1;
   localparam logic [ADDR_W-1:0] LAST = ADDR_W'(BLOCK_LEN - 1);

   viterbi_pkg::decision_t bank_mem [4][BLOCK_LEN];
   viterbi_pkg::decision_t rd_word [4];
   viterbi_pkg::decision_t train_word;
   viterbi_pkg::decision_t decode_word;

   logic [ADDR_W-1:0] wr_cnt;
   logic [ADDR_W-1:0] rd_cnt;
   logic [1:0]        bank;
   logic [1:0]        bank_d;
   logic              en_d;
   logic              active_0;
   logic              active_1;

   // Decisions lag the symbol by one cycle, so counting starts one cycle late
   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         en_d   <= 1'b0;
         wr_cnt <= '0;
         rd_cnt <= LAST;
         bank   <= 2'd0;
      end
      else if (!enable_i)
      begin
         en_d   <= 1'b0;
         wr_cnt <= '0;
         rd_cnt <= LAST;
         bank   <= 2'd0;
      end
      else
      begin
         en_d <= 1'b1;
         if (en_d)
         begin
            wr_cnt <= (wr_cnt == LAST) ? '0 : wr_cnt + 1'b1;
            rd_cnt <= (rd_cnt == '0) ? LAST : rd_cnt - 1'b1;
            if (wr_cnt == LAST)
               bank <= bank + 2'd1;
         end
      end
   end

   // bank_d lines up with the registered read data
   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         bank_d   <= 2'd0;
         active_0 <= 1'b0;
         active_1 <= 1'b0;
      end
      else if (!enable_i)
      begin
         bank_d   <= 2'd0;
         active_0 <= 1'b0;
         active_1 <= 1'b0;
      end
      else
      begin
         bank_d <= bank;
         if (bank == 2'd2)
            active_0 <= 1'b1;
         if (bank == 2'd3)
            active_1 <= 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (en_d)
         bank_mem[bank][wr_cnt] <= decision_i;
      for (int k = 0; k < 4; k++)
         rd_word[k] <= bank_mem[k][rd_cnt];
   end

   // Newest full block trains, the one three banks back decodes
   always_comb
   begin
      train_word  = rd_word[bank_d - 2'd1];
      decode_word = rd_word[bank_d + 2'd1];

      feed_0_o.active       = active_0;
      feed_0_o.decode_phase = bank_d[0];
      feed_0_o.train_word   = train_word;
      feed_0_o.decode_word  = decode_word;

      feed_1_o.active       = active_1;
      feed_1_o.decode_phase = ~bank_d[0];
      feed_1_o.train_word   = train_word;
      feed_1_o.decode_word  = decode_word;
   end

endmodule

/* src/traceback_unit.sv */
`timescale 1ns/1ps

module traceback_unit
(
   input  logic                  clk,
   input  logic                  rst,
   input  viterbi_pkg::tb_feed_t feed_i,
   output viterbi_pkg::tb_bit_t  bit_o
);

   localparam int SW = viterbi_pkg::STATE_W;

   logic [SW-1:0]          state_q;
   logic [SW-1:0]          pred;
   logic                   phase_d;
   viterbi_pkg::decision_t word;

   // Walk one step back through the trellis
   always_comb
   begin
      word = feed_i.decode_phase ? feed_i.decode_word : feed_i.train_word;
      pred = {word[state_q], state_q[SW-1:1]};
   end

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         state_q <= '0;
         phase_d <= 1'b0;
      end
      else
      begin
         phase_d <= feed_i.decode_phase;
         if (!feed_i.active)
            state_q <= '0;
         // New training block starts from state 0
         else if (phase_d && !feed_i.decode_phase)
            state_q <= '0;
         else
            state_q <= pred;
      end
   end

   // Low state bit is the input that entered this state
   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         bit_o.valid <= 1'b0;
         bit_o.data  <= 1'b0;
      end
      else
      begin
         bit_o.valid <= feed_i.active & feed_i.decode_phase;
         bit_o.data  <= state_q[0];
      end
   end

endmodule

/* src/viterbi_decoder.sv */
`timescale 1ns/1ps

module viterbi_decoder
#(
   parameter int PM_W      = viterbi_pkg::PM_W_DEFAULT,
   parameter int BLOCK_LEN = viterbi_pkg::BLOCK_LEN_DEFAULT
)
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 enable_i,
   input  viterbi_pkg::symbol_t symbol_i,
   output logic                 bit_o,
   output logic                 bit_valid_o
);

   logic [2*viterbi_pkg::NUM_STATES-1:0][viterbi_pkg::BM_W-1:0] bm;
   viterbi_pkg::decision_t decision;
   viterbi_pkg::tb_feed_t  feed_0;
   viterbi_pkg::tb_feed_t  feed_1;
   viterbi_pkg::tb_bit_t   tb_bit_0;
   viterbi_pkg::tb_bit_t   tb_bit_1;

   branch_metric u_bm
   (
      .symbol_i (symbol_i),
      .bm_o     (bm)
   );

   acs_array #(.PM_W(PM_W)) u_acs
   (
      .clk        (clk),
      .rst        (rst),
      .enable_i   (enable_i),
      .bm_i       (bm),
      .decision_o (decision)
   );

   survivor_memory #(.BLOCK_LEN(BLOCK_LEN)) u_smu
   (
      .clk        (clk),
      .rst        (rst),
      .enable_i   (enable_i),
      .decision_i (decision),
      .feed_0_o   (feed_0),
      .feed_1_o   (feed_1)
   );

   traceback_unit tbu_0
   (
      .clk    (clk),
      .rst    (rst),
      .feed_i (feed_0),
      .bit_o  (tb_bit_0)
   );

   traceback_unit tbu_1
   (
      .clk    (clk),
      .rst    (rst),
      .feed_i (feed_1),
      .bit_o  (tb_bit_1)
   );

   bit_reorder #(.BLOCK_LEN(BLOCK_LEN)) u_reorder
   (
      .clk         (clk),
      .rst         (rst),
      .enable_i    (enable_i),
      .bit_0_i     (tb_bit_0),
      .bit_1_i     (tb_bit_1),
      .bit_o       (bit_o),
      .bit_valid_o (bit_valid_o)
   );

endmodule

/* src/viterbi_pkg.sv */
package viterbi_pkg;

   // Trellis size for constraint length 4
   localparam int NUM_STATES = 8;
   localparam int STATE_W    = 3;
   localparam int SYMBOL_W   = 2;

   // Taps over {state, new bit}, new bit in bit 0
   // symbol[0] comes from GEN_0, symbol[1] from GEN_1
   localparam logic [STATE_W:0] GEN_0 = 4'b1101;
   localparam logic [STATE_W:0] GEN_1 = 4'b1111;

   // Hamming distance of a 2-bit symbol is at most 2
   localparam int BM_W = 2;

   localparam int PM_W_DEFAULT      = 8;
   localparam int BLOCK_LEN_DEFAULT = 16;

   typedef logic [SYMBOL_W-1:0] symbol_t;

   // Bit s set when state s came from the predecessor with its high bit set
   typedef logic [NUM_STATES-1:0] decision_t;

   typedef struct packed {
      logic      active;
      logic      decode_phase;
      decision_t train_word;
      decision_t decode_word;
   } tb_feed_t;

   // One traceback output, data is the decoded bit
   typedef struct packed {
      logic valid;
      logic data;
   } tb_bit_t;

endpackage

/* viterbi_decoder.f */
src/viterbi_pkg.sv
src/branch_metric.sv
src/acs_array.sv
src/survivor_memory.sv
src/traceback_unit.sv
src/bit_reorder.sv
src/viterbi_decoder.sv
dv/tb_viterbi_decoder.sv
